/* design/astral_pkg.sv */
/*
 * astral pad control package
 * sizes, register map, pad function encoding and the
 * configuration word shared by the register port and the pad logic
 */

package astral_pkg;

  //////////////////////////////
  // sizes
  //////////////////////////////

  localparam int unsigned NumMuxedPads = 22;
  localparam int unsigned PadSelW      = 2;
  localparam int unsigned PadsPerWord  = 16;
  localparam int unsigned NumHiPads    = NumMuxedPads - PadsPerWord;

  localparam int unsigned RegAddrW = 4;
  localparam int unsigned RegDataW = 32;

  // real-time clock divider, toggles every half ratio
  localparam int unsigned RtDivValue = 100;
  localparam int unsigned RtHalfDiv  = RtDivValue / 2;
  localparam int unsigned RtCntW     = $clog2(RtHalfDiv);

  localparam int unsigned BootModeW = 2;

  // straps are taken in the second cycle after reset
  localparam int unsigned StrapCntW       = 2;
  localparam int unsigned StrapCaptureCnt = 1;

  //////////////////////////////
  // register map
  //////////////////////////////

  localparam logic [RegAddrW-1:0] AddrPadSelLo = 4'd0;
  localparam logic [RegAddrW-1:0] AddrPadSelHi = 4'd1;
  localparam logic [RegAddrW-1:0] AddrCtrl     = 4'd2;
  localparam logic [RegAddrW-1:0] AddrStatus   = 4'd3;

  localparam logic [RegDataW-1:0] UnmappedRdata = 32'hCACA_BABE;

  typedef enum logic [PadSelW-1:0] {
    PadFnGpio  = 2'd0,
    PadFnUart  = 2'd1,
    PadFnRtClk = 2'd2,
    PadFnOff   = 2'd3
  } pad_fn_e;

  // one register word, seen as sixteen pad selects or as control bits
  typedef union packed {
    pad_fn_e [PadsPerWord-1:0] sel;
    struct packed {
      logic [RegDataW-3:0] rsvd;
      logic                rt_en;
      logic                pad_en;
    } ctrl;
  } cfg_word_u;

endpackage

/* design/pad_in_sync.sv */
/*
 * pad input synchronizer
 * two-flop synchronizers on pad inputs and boot straps,
 * straps latched once after reset and held
 */

`timescale 1ns/10ps

module pad_in_sync (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic [astral_pkg::NumMuxedPads-1:0]  pad_in_i,
  input  logic [astral_pkg::BootModeW-1:0]     boot_mode_i,
  input  logic                                 secure_boot_i,
  output logic [astral_pkg::NumMuxedPads-1:0]  pad_in_sync_o,
  output logic [astral_pkg::BootModeW-1:0]     boot_mode_o,
  output logic                                 secure_boot_o
);

  import astral_pkg::*;

  logic [NumMuxedPads-1:0] pad_meta_q;
  logic [BootModeW:0]      strap_meta_q;
  logic [BootModeW:0]      strap_sync_q;
  logic [StrapCntW-1:0]    cnt_q;

  // synchronizer chain, settles while reset is held
  always_ff @(posedge clk_i) begin
    pad_meta_q    <= pad_in_i;
    pad_in_sync_o <= pad_meta_q;
    strap_meta_q  <= {secure_boot_i, boot_mode_i};
    strap_sync_q  <= strap_meta_q;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q         <= '0;
      boot_mode_o   <= '0;
      secure_boot_o <= 1'b0;
    end else begin
      if (cnt_q <= StrapCntW'(StrapCaptureCnt)) begin
        cnt_q <= cnt_q + 1'b1;
      end
      if (cnt_q == StrapCntW'(StrapCaptureCnt)) begin
        {secure_boot_o, boot_mode_o} <= strap_sync_q;
      end
    end
  end

endmodule

/* design/pad_cfg_regs.sv */
/*
 * pad configuration registers
 * request/ready register port holding the pad select table,
 * the control bits and a read-only boot status word
 */

`timescale 1ns/10ps

module pad_cfg_regs (
  input  logic                                              clk_i,
  input  logic                                              rst_i,
  input  logic                                              reg_req_i,
  input  logic                                              reg_we_i,
  input  logic [astral_pkg::RegAddrW-1:0]                   reg_addr_i,
  input  astral_pkg::cfg_word_u                             reg_wdata_i,
  input  logic [astral_pkg::BootModeW-1:0]                  boot_mode_i,
  input  logic                                              secure_boot_i,
  output logic                                              reg_ready_o,
  output logic                                              reg_error_o,
  output logic [astral_pkg::RegDataW-1:0]                   reg_rdata_o,
  output astral_pkg::pad_fn_e [astral_pkg::NumMuxedPads-1:0] pad_sel_o,
  output logic                                              pad_en_o,
  output logic                                              rt_en_o
);

  import astral_pkg::*;

  logic [BootModeW-1:0] sec_boot_mode;
  logic [RegDataW-1:0]  status_word;
  cfg_word_u            rd_word;
  logic                 req_err;
  logic                 wr_en;

  // secure domain boots from its strap only
  assign sec_boot_mode = {1'b0, secure_boot_i};
  assign status_word   = {{(RegDataW-6){1'b0}}, sec_boot_mode, 1'b0, secure_boot_i, boot_mode_i};

  assign req_err = (reg_addr_i > AddrStatus) || (reg_we_i && (reg_addr_i == AddrStatus));
  assign wr_en   = reg_req_i && reg_we_i && !req_err;

  //////////////////////////////
  // readback
  //////////////////////////////

  always_comb begin
    rd_word = '0;
    case (reg_addr_i)
      AddrPadSelLo: rd_word.sel = pad_sel_o[PadsPerWord-1:0];
      AddrPadSelHi: rd_word.sel[NumHiPads-1:0] = pad_sel_o[NumMuxedPads-1:PadsPerWord];
      AddrCtrl: begin
        rd_word.ctrl.pad_en = pad_en_o;
        rd_word.ctrl.rt_en  = rt_en_o;
      end
      AddrStatus: rd_word = status_word;
      default:    rd_word = UnmappedRdata;
    endcase
  end

  //////////////////////////////
  // config state
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < NumMuxedPads; i++) begin
        pad_sel_o[i] <= PadFnGpio;
      end
      pad_en_o <= 1'b0;
      rt_en_o  <= 1'b0;
    end else if (wr_en) begin
      case (reg_addr_i)
        AddrPadSelLo: pad_sel_o[PadsPerWord-1:0] <= reg_wdata_i.sel;
        AddrPadSelHi: pad_sel_o[NumMuxedPads-1:PadsPerWord] <= reg_wdata_i.sel[NumHiPads-1:0];
        AddrCtrl: begin
          pad_en_o <= reg_wdata_i.ctrl.pad_en;
          rt_en_o  <= reg_wdata_i.ctrl.rt_en;
        end
        default: ;
      endcase
    end
  end

  // response one cycle after the request
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      reg_ready_o <= 1'b0;
      reg_error_o <= 1'b0;
    end else begin
      reg_ready_o <= reg_req_i;
      reg_error_o <= reg_req_i && req_err;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reg_req_i) begin
      reg_rdata_o <= rd_word;
    end
  end

endmodule

/* design/rt_clk_div.sv */
/*
 * real-time clock divider
 * divides the reference clock by RtDivValue, held low when disabled
 */

`timescale 1ns/10ps

module rt_clk_div (
  input  logic clk_i,
  input  logic rst_i,
  input  logic en_i,
  output logic rt_clk_o
);

  import astral_pkg::*;

  logic [RtCntW-1:0] cnt_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q    <= '0;
      rt_clk_o <= 1'b0;
    end else if (!en_i) begin
      // restart from a known phase
      cnt_q    <= '0;
      rt_clk_o <= 1'b0;
    end else if (cnt_q == RtCntW'(RtHalfDiv - 1)) begin
      cnt_q    <= '0;
      rt_clk_o <= ~rt_clk_o;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

endmodule

/* design/pad_mux.sv */
/*
 * pad function mux
 * routes GPIO, UART and the real-time clock onto the muxed pads
 * and back from the synchronized pad inputs
 */

`timescale 1ns/10ps

module pad_mux (
  input  astral_pkg::pad_fn_e [astral_pkg::NumMuxedPads-1:0] pad_sel_i,
  input  logic [astral_pkg::NumMuxedPads-1:0]                 pad_in_sync_i,
  input  logic [astral_pkg::NumMuxedPads-1:0]                 gpio_i,
  input  logic [astral_pkg::NumMuxedPads-1:0]                 gpio_oe_i,
  input  logic                                                uart_tx_i,
  input  logic                                                rt_clk_i,
  output logic [astral_pkg::NumMuxedPads-1:0]                 pad_out_o,
  output logic [astral_pkg::NumMuxedPads-1:0]                 pad_oe_o,
  output logic [astral_pkg::NumMuxedPads-1:0]                 gpio_in_o,
  output logic                                                uart_rx_o
);

  import astral_pkg::*;

  //////////////////////////////
  // soc to pad
  //////////////////////////////

  always_comb begin
    for (int i = 0; i < NumMuxedPads; i++) begin
      case (pad_sel_i[i])
        PadFnGpio: begin
          pad_out_o[i] = gpio_i[i];
          pad_oe_o[i]  = gpio_oe_i[i];
        end
        PadFnUart: begin
          pad_out_o[i] = uart_tx_i;
          pad_oe_o[i]  = 1'b1;
        end
        PadFnRtClk: begin
          pad_out_o[i] = rt_clk_i;
          pad_oe_o[i]  = 1'b1;
        end
        default: begin
          pad_out_o[i] = 1'b0;
          pad_oe_o[i]  = 1'b0;
        end
      endcase
    end
  end

  //////////////////////////////
  // pad to soc
  //////////////////////////////

  always_comb begin
    for (int i = 0; i < NumMuxedPads; i++) begin
      gpio_in_o[i] = (pad_sel_i[i] == PadFnGpio) && pad_in_sync_i[i];
    end
  end

  // lowest index UART pad wins, idle high otherwise
  always_comb begin
    uart_rx_o = 1'b1;
    for (int i = NumMuxedPads - 1; i >= 0; i--) begin
      if (pad_sel_i[i] == PadFnUart) begin
        uart_rx_o = pad_in_sync_i[i];
      end
    end
  end

endmodule

/* design/pad_drive.sv */
/*
 * pad output stage
 * registered pad values and enables, quiet until pads are enabled
 */

`timescale 1ns/10ps

module pad_drive (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic                                pad_en_i,
  input  logic [astral_pkg::NumMuxedPads-1:0] pad_out_i,
  input  logic [astral_pkg::NumMuxedPads-1:0] pad_oe_i,
  output logic [astral_pkg::NumMuxedPads-1:0] pad_out_o,
  output logic [astral_pkg::NumMuxedPads-1:0] pad_oe_o
);

  import astral_pkg::*;

  logic [NumMuxedPads-1:0] out_q;
  logic [NumMuxedPads-1:0] oe_q;

  always_ff @(posedge clk_i) begin
    if (rst_i || !pad_en_i) begin
      out_q <= '0;
      oe_q  <= '0;
    end else begin
      out_q <= pad_out_i;
      oe_q  <= pad_oe_i;
    end
  end

  // disable takes effect at once, not a cycle late
  assign pad_out_o = out_q & {NumMuxedPads{pad_en_i}};
  assign pad_oe_o  = oe_q & {NumMuxedPads{pad_en_i}};

endmodule

/* design/astral_pad_ctrl.sv */
/*
 * astral pad and clock control
 * boot straps, muxed pad routing, real-time clock and the
 * pad configuration register port
 */

`timescale 1ns/10ps

module astral_pad_ctrl (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic                                reg_req_i,
  input  logic                                reg_we_i,
  input  logic [astral_pkg::RegAddrW-1:0]     reg_addr_i,
  input  astral_pkg::cfg_word_u               reg_wdata_i,
  output logic                                reg_ready_o,
  output logic                                reg_error_o,
  output logic [astral_pkg::RegDataW-1:0]     reg_rdata_o,
  input  logic [astral_pkg::BootModeW-1:0]    boot_mode_i,
  input  logic                                secure_boot_i,
  input  logic [astral_pkg::NumMuxedPads-1:0] pad_in_i,
  input  logic [astral_pkg::NumMuxedPads-1:0] gpio_o,
  input  logic [astral_pkg::NumMuxedPads-1:0] gpio_oe_i,
  input  logic                                uart_tx_i,
  output logic [astral_pkg::NumMuxedPads-1:0] pad_out_o,
  output logic [astral_pkg::NumMuxedPads-1:0] pad_oe_o,
  output logic [astral_pkg::NumMuxedPads-1:0] gpio_in_o,
  output logic                                uart_rx_o,
  output logic                                rt_clk_o,
  output logic [astral_pkg::BootModeW-1:0]    boot_mode_o,
  output logic                                secure_boot_o
);

  import astral_pkg::*;

  pad_fn_e [NumMuxedPads-1:0] pad_sel;
  logic [NumMuxedPads-1:0]    pad_in_sync;
  logic [NumMuxedPads-1:0]    mux_out;
  logic [NumMuxedPads-1:0]    mux_oe;
  logic                       pad_en;
  logic                       rt_en;

  //////////////////////////////
  // input side
  //////////////////////////////

  pad_in_sync i_pad_in_sync (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .pad_in_i      ( pad_in_i      ),
    .boot_mode_i   ( boot_mode_i   ),
    .secure_boot_i ( secure_boot_i ),
    .pad_in_sync_o ( pad_in_sync   ),
    .boot_mode_o   ( boot_mode_o   ),
    .secure_boot_o ( secure_boot_o )
  );

  pad_cfg_regs i_pad_cfg_regs (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .reg_req_i     ( reg_req_i     ),
    .reg_we_i      ( reg_we_i      ),
    .reg_addr_i    ( reg_addr_i    ),
    .reg_wdata_i   ( reg_wdata_i   ),
    .boot_mode_i   ( boot_mode_o   ),
    .secure_boot_i ( secure_boot_o ),
    .reg_ready_o   ( reg_ready_o   ),
    .reg_error_o   ( reg_error_o   ),
    .reg_rdata_o   ( reg_rdata_o   ),
    .pad_sel_o     ( pad_sel       ),
    .pad_en_o      ( pad_en        ),
    .rt_en_o       ( rt_en         )
  );

  //////////////////////////////
  // processing
  //////////////////////////////

  rt_clk_div i_rt_clk_div (
    .clk_i    ( clk_i    ),
    .rst_i    ( rst_i    ),
    .en_i     ( rt_en    ),
    .rt_clk_o ( rt_clk_o )
  );

  pad_mux i_pad_mux (
    .pad_sel_i     ( pad_sel     ),
    .pad_in_sync_i ( pad_in_sync ),
    .gpio_i        ( gpio_o      ),
    .gpio_oe_i     ( gpio_oe_i   ),
    .uart_tx_i     ( uart_tx_i   ),
    .rt_clk_i      ( rt_clk_o    ),
    .pad_out_o     ( mux_out     ),
    .pad_oe_o      ( mux_oe      ),
    .gpio_in_o     ( gpio_in_o   ),
    .uart_rx_o     ( uart_rx_o   )
  );

  //////////////////////////////
  // output side
  //////////////////////////////

  pad_drive i_pad_drive (
    .clk_i     ( clk_i     ),
    .rst_i     ( rst_i     ),
    .pad_en_i  ( pad_en    ),
    .pad_out_i ( mux_out   ),
    .pad_oe_i  ( mux_oe    ),
    .pad_out_o ( pad_out_o ),
    .pad_oe_o  ( pad_oe_o  )
  );

endmodule

/* tests/astral_pad_ctrl_properties.sv */
/*
 * pad control properties
 * register port response timing and pad output gating
 */

`timescale 1ns/10ps

module astral_pad_ctrl_properties (
  input logic                                clk_i,
  input logic                                rst_i,
  input logic                                reg_req_i,
  input logic                                reg_ready_i,
  input logic                                reg_error_i,
  input logic                                pad_en_i,
  input logic [astral_pkg::NumMuxedPads-1:0] pad_oe_i
);

  // ready exactly one cycle after a request, never otherwise
  ready_after_req: assert property (@(posedge clk_i) disable iff (rst_i)
    reg_req_i |=> reg_ready_i)
    else $error("register ready missing one cycle after a request");

  ready_only_after_req: assert property (@(posedge clk_i) disable iff (rst_i)
    !reg_req_i |=> !reg_ready_i)
    else $error("register ready without a request in the cycle before");

  error_with_ready: assert property (@(posedge clk_i)
    reg_error_i |-> reg_ready_i)
    else $error("register error raised outside a ready pulse");

  oe_gated: assert property (@(posedge clk_i)
    !pad_en_i |-> (pad_oe_i == '0))
    else $error("pad output enable active while pads are disabled");

endmodule

bind astral_pad_ctrl astral_pad_ctrl_properties props (
  .clk_i       ( clk_i       ),
  .rst_i       ( rst_i       ),
  .reg_req_i   ( reg_req_i   ),
  .reg_ready_i ( reg_ready_o ),
  .reg_error_i ( reg_error_o ),
  .pad_en_i    ( pad_en      ),
  .pad_oe_i    ( pad_oe_o    )
);

/* tests/tb_astral_pad_ctrl.sv */
/*
 * testbench for the astral pad control block
 * runs the operations of the stimulus file against the DUT
 * and checks responses with a model of the select rules
 */

`timescale 1ns/10ps

module tb_astral_pad_ctrl;

  import astral_pkg::*;

  localparam int unsigned ResetCycles     = 16;
  localparam int unsigned CyclesPerVector = 300;

  logic                    clk_i = 1'b0;
  logic                    rst_i;
  logic                    reg_req_i;
  logic                    reg_we_i;
  logic [RegAddrW-1:0]     reg_addr_i;
  logic [RegDataW-1:0]     reg_wdata_i;
  logic                    reg_ready_o;
  logic                    reg_error_o;
  logic [RegDataW-1:0]     reg_rdata_o;
  logic [BootModeW-1:0]    boot_mode_i;
  logic                    secure_boot_i;
  logic [NumMuxedPads-1:0] pad_in_i;
  logic [NumMuxedPads-1:0] gpio_o;
  logic [NumMuxedPads-1:0] gpio_oe_i;
  logic                    uart_tx_i;
  logic [NumMuxedPads-1:0] pad_out_o;
  logic [NumMuxedPads-1:0] pad_oe_o;
  logic [NumMuxedPads-1:0] gpio_in_o;
  logic                    uart_rx_o;
  logic                    rt_clk_o;
  logic [BootModeW-1:0]    boot_mode_o;
  logic                    secure_boot_o;

  // stimulus vectors and the expected configuration state
  byte         op_q[$];
  logic [31:0] arg_a_q[$];
  logic [31:0] arg_b_q[$];
  logic [31:0] arg_c_q[$];
  logic [1:0]  sel_model [NumMuxedPads];
  logic        pad_en_model;
  logic        rt_en_model;
  logic [31:0] rng_state   = 32'h92013476;
  int unsigned cycle_cnt   = 0;
  int unsigned cycle_limit = 0;
  int unsigned num_checks  = 0;
  int unsigned num_errors  = 0;
  int unsigned num_tests   = 0;
  bit          loaded;

  astral_pad_ctrl dut (.*);

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_limit != 0 && cycle_cnt > cycle_limit) begin
      $display("run timed out after %0d cycles before the stimulus was done", cycle_cnt);
      $display("*** FAILED ***");
      $finish;
    end
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  // inputs change 1 ns after the rising edge
  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    num_checks++;
    if (exp !== act) begin
      num_errors++;
      $display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic report_error(input string msg);
    num_errors++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic apply_reset();
    rst_i = 1'b1;
    for (int i = 0; i < NumMuxedPads; i++) begin
      sel_model[i] = PadFnGpio;
    end
    pad_en_model = 1'b0;
    rt_en_model  = 1'b0;
    repeat (ResetCycles) step();
    rst_i = 1'b0;
  endtask

  task automatic reg_access(input logic we, input logic [RegAddrW-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err, output logic ok);
    int waited;
    reg_req_i   = 1'b1;
    reg_we_i    = we;
    reg_addr_i  = addr;
    reg_wdata_i = wdata;
    step();
    reg_req_i = 1'b0;
    reg_we_i  = 1'b0;
    waited    = 1;
    while (!reg_ready_o && waited < 8) begin
      step();
      waited++;
    end
    ok    = reg_ready_o;
    rdata = reg_rdata_o;
    err   = reg_error_o;
    if (!ok) begin
      report_error("register port gave no ready response");
    end else begin
      compare("reg_ready_o latency", 32'd1, 32'(waited));
    end
  endtask

  task automatic update_model(input logic [RegAddrW-1:0] addr, input logic [31:0] data);
    case (addr)
      AddrPadSelLo: begin
        for (int i = 0; i < PadsPerWord; i++) begin
          sel_model[i] = data[2*i +: 2];
        end
      end
      AddrPadSelHi: begin
        for (int i = 0; i < NumHiPads; i++) begin
          sel_model[PadsPerWord+i] = data[2*i +: 2];
        end
      end
      AddrCtrl: begin
        pad_en_model = data[0];
        rt_en_model  = data[1];
      end
      default: ;
    endcase
  endtask

  // rt clock pads are left out of the value compare while the clock runs
  task automatic predict_pads(input logic [NumMuxedPads-1:0] g, input logic [NumMuxedPads-1:0] g_oe,
                              input logic tx, output logic [NumMuxedPads-1:0] out,
                              output logic [NumMuxedPads-1:0] oe,
                              output logic [NumMuxedPads-1:0] care);
    for (int i = 0; i < NumMuxedPads; i++) begin
      care[i] = 1'b1;
      case (sel_model[i])
        PadFnGpio: begin
          out[i] = g[i];
          oe[i]  = g_oe[i];
        end
        PadFnUart: begin
          out[i] = tx;
          oe[i]  = 1'b1;
        end
        PadFnRtClk: begin
          out[i]  = 1'b0;
          oe[i]   = 1'b1;
          care[i] = !rt_en_model;
        end
        default: begin
          out[i] = 1'b0;
          oe[i]  = 1'b0;
        end
      endcase
    end
    if (!pad_en_model) begin
      out = '0;
      oe  = '0;
    end
  endtask

  task automatic predict_inputs(input logic [NumMuxedPads-1:0] pin,
                                output logic [NumMuxedPads-1:0] gin, output logic rx);
    bit found;
    found = 1'b0;
    rx    = 1'b1;
    for (int i = 0; i < NumMuxedPads; i++) begin
      gin[i] = (sel_model[i] == PadFnGpio) && pin[i];
      if (!found && sel_model[i] == PadFnUart) begin
        rx    = pin[i];
        found = 1'b1;
      end
    end
  endtask

  task automatic load_vectors(output bit ok);
    int          fd;
    int          n;
    string       line;
    byte         op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    ok = 1'b0;
    fd = $fopen("tests/pad_ctrl_input.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        n    = $fgets(line, fd);
        if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%c %h %h %h", op, a, b, c);
          if (n == 4) begin
            op_q.push_back(op);
            arg_a_q.push_back(a);
            arg_b_q.push_back(b);
            arg_c_q.push_back(c);
          end
        end
      end
      $fclose(fd);
      ok = (op_q.size() > 0);
    end
  endtask

  //////////////////////////////
  // one stimulus line
  //////////////////////////////

  task automatic run_vector(input int idx);
    byte                     op;
    logic [31:0]             a;
    logic [31:0]             b;
    logic [31:0]             c;
    logic [31:0]             rdata;
    logic [31:0]             rnd;
    logic                    err;
    logic                    ok;
    logic [NumMuxedPads-1:0] exp_out;
    logic [NumMuxedPads-1:0] exp_oe;
    logic [NumMuxedPads-1:0] care;
    logic                    exp_rx;
    logic [NumMuxedPads-1:0] prev_out;
    logic [NumMuxedPads-1:0] prev_oe;
    logic [NumMuxedPads-1:0] prev_gin;
    logic                    prev_rx;
    int                      pad;
    int                      half;
    int                      waited;
    int unsigned             errs_before;
    op          = op_q[idx];
    a           = arg_a_q[idx];
    b           = arg_b_q[idx];
    c           = arg_c_q[idx];
    errs_before = num_errors;
    case (op)
      "S": begin
        boot_mode_i   = a[BootModeW-1:0];
        secure_boot_i = b[0];
        apply_reset();
        // straps are captured in the second cycle after reset
        repeat (2) step();
        compare("boot_mode_o", 32'(a[BootModeW-1:0]), 32'(boot_mode_o));
        compare("secure_boot_o", 32'(b[0]), 32'(secure_boot_o));
        compare("pad_out_o", 32'd0, 32'(pad_out_o));
        compare("pad_oe_o", 32'd0, 32'(pad_oe_o));
        compare("rt_clk_o", 32'd0, 32'(rt_clk_o));
        // latched straps ignore later changes on the pins
        boot_mode_i   = ~a[BootModeW-1:0];
        secure_boot_i = ~b[0];
        repeat (4) step();
        compare("boot_mode_o", 32'(a[BootModeW-1:0]), 32'(boot_mode_o));
        compare("secure_boot_o", 32'(b[0]), 32'(secure_boot_o));
      end
      "W", "R": begin
        reg_access(op == "W", a[RegAddrW-1:0], b, rdata, err, ok);
        if (ok) begin
          compare("reg_error_o", 32'(c[0]), 32'(err));
          if (op == "R") begin
            compare("reg_rdata_o", b, rdata);
          end else if (!c[0]) begin
            update_model(a[RegAddrW-1:0], b);
          end
        end
      end
      "G": begin
        for (int n = 0; n < int'(a); n++) begin
          rnd       = next_random();
          gpio_o    = rnd[NumMuxedPads-1:0];
          rnd       = next_random();
          gpio_oe_i = rnd[NumMuxedPads-1:0];
          uart_tx_i = rnd[31];
          // registered pads keep the old value until the edge
          #1;
          if (n > 0) begin
            compare("pad_out_o", 32'(prev_out & care), 32'(pad_out_o & care));
            compare("pad_oe_o", 32'(prev_oe), 32'(pad_oe_o));
          end
          predict_pads(gpio_o, gpio_oe_i, uart_tx_i, exp_out, exp_oe, care);
          step();
          compare("pad_out_o", 32'(exp_out & care), 32'(pad_out_o & care));
          compare("pad_oe_o", 32'(exp_oe), 32'(pad_oe_o));
          prev_out = exp_out;
          prev_oe  = exp_oe;
        end
      end
      "P": begin
        predict_inputs(pad_in_i, prev_gin, prev_rx);
        for (int n = 0; n < int'(a); n++) begin
          rnd      = next_random();
          pad_in_i = rnd[NumMuxedPads-1:0];
          predict_inputs(pad_in_i, exp_out, exp_rx);
          // old value still shows after the first edge
          step();
          compare("gpio_in_o", 32'(prev_gin), 32'(gpio_in_o));
          compare("uart_rx_o", 32'(prev_rx), 32'(uart_rx_o));
          step();
          compare("gpio_in_o", 32'(exp_out), 32'(gpio_in_o));
          compare("uart_rx_o", 32'(exp_rx), 32'(uart_rx_o));
          prev_gin = exp_out;
          prev_rx  = exp_rx;
        end
      end
      "C": begin
        pad    = int'(a);
        half   = int'(b);
        waited = 0;
        while (!rt_clk_o && waited < 2 * half + 4) begin
          step();
          waited++;
        end
        if (!rt_clk_o) begin
          report_error("real-time clock never went high after it was enabled");
        end else begin
          // clock starts low and first rises half a period after enable
          compare("rt_clk_o first rise", 32'(half), 32'(waited));
          // t counts from the first high sample, the pad lags by one cycle
          for (int t = 0; t <= 2 * half; t++) begin
            compare("rt_clk_o", 32'((t % (2 * half)) < half), 32'(rt_clk_o));
            compare("pad_out_o[rt pad]", 32'(t >= 1 && ((t - 1) % (2 * half)) < half),
                    32'(pad_out_o[pad]));
            compare("pad_oe_o[rt pad]", 32'd1, 32'(pad_oe_o[pad]));
            step();
          end
        end
      end
      "L": begin
        step();
        for (int n = 0; n < int'(a); n++) begin
          compare("rt_clk_o", 32'd0, 32'(rt_clk_o));
          step();
        end
      end
      default: report_error($sformatf("unknown operation in stimulus line %0d", idx + 1));
    endcase
    num_tests++;
    $display("test %0d (%c): %s", idx + 1, op, (num_errors == errs_before) ? "ok" : "failed");
  endtask

  initial begin
    rst_i         = 1'b1;
    reg_req_i     = 1'b0;
    reg_we_i      = 1'b0;
    reg_addr_i    = '0;
    reg_wdata_i   = '0;
    boot_mode_i   = '0;
    secure_boot_i = 1'b0;
    pad_in_i      = '0;
    gpio_o        = '0;
    gpio_oe_i     = '0;
    uart_tx_i     = 1'b1;
    load_vectors(loaded);
    if (!loaded) begin
      $display("stimulus file tests/pad_ctrl_input.txt could not be read");
      $display("*** FAILED ***");
      $finish;
    end else begin
      cycle_limit = op_q.size() * CyclesPerVector + ResetCycles;
      apply_reset();
      for (int i = 0; i < op_q.size(); i++) begin
        run_vector(i);
      end
      $display("tests %0d, checks %0d, errors %0d", num_tests, num_checks, num_errors);
      if (num_errors == 0) begin
        $display("*** PASSED ***");
      end else begin
        $display("*** FAILED ***");
      end
      $finish;
    end
  end

endmodule

/* tests/pad_ctrl_input.txt */
# columns: op a b c, values in hex
# S boot secure 0 | W addr data err | R addr expected err | G count | P count | C pad half | L count
S 2 1 0
R 3 16 0
R 0 0 0
R 1 0 0
R 2 0 0
G 8 0 0
W 0 a5a5a5a5 0
R 0 a5a5a5a5 0
W 1 fffff1b9 0
R 1 000001b9 0
W 2 fffffffe 0
R 2 2 0
R 9 cacababe 1
W 9 1 1
W 3 ffffffff 1
R 3 16 0
W 0 0 0
W 1 0 0
W 2 0 0
G 8 0 0
W 2 1 0
G 20 0 0
P 20 0 0
W 0 d1ff 0
W 1 d00 0
G 20 0 0
P 20 0 0
W 0 ff 0
P 10 0 0
W 0 20 0
W 1 0 0
W 2 3 0
C 2 32 0
W 2 1 0
L 64 0 0
G 8 0 0
S 1 0 0
R 3 1 0

/* src.f */
design/astral_pkg.sv
design/pad_in_sync.sv
design/pad_cfg_regs.sv
design/rt_clk_div.sv
design/pad_mux.sv
design/pad_drive.sv
design/astral_pad_ctrl.sv
tests/astral_pad_ctrl_properties.sv
tests/tb_astral_pad_ctrl.sv

/* Makefile */
# Verilator build and run for the astral pad control testbench

VERILATOR  ?= verilator
TOP        ?= tb_astral_pad_ctrl
FILELIST   ?= src.f
BUILD_DIR  ?= build
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert
PASS_MSG   ?= *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
